// ==== all.f ====
+incdir+verilog
+incdir+test
verilog/fifo_pkg.sv
verilog/fifo_ctrl.sv
verilog/fifo_level.sv
verilog/fifo_ram.sv
verilog/fifo_top.sv
test/tb_fifo_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the fifo testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/1ns \
    --top-module tb_fifo_top \
    -Mdir obj_dir -o sim_fifo \
    -f all.f

output="$(./obj_dir/sim_fifo)"
echo "$output"

if echo "$output" | grep -q "ALL CHECKS PASSED"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

// ==== test/tb_fifo_tests.svh ====
//------------------------------------------------
// directed tests for the width converting fifo
// reset, ordering, full, empty, programmable flags
//------------------------------------------------

`ifndef TB_FIFO_TESTS_SVH
`define TB_FIFO_TESTS_SVH

// still inside reset, flops hold their reset values
task automatic test_reset();
    test_name = "test_reset";
    check_status();
    check_value("rempty", 1, 32'(flags.rempty));
    check_value("wr_data_cnt", 0, 32'(wr_data_cnt));
    check_value("rd_data_cnt", 0, 32'(rd_data_cnt));
endtask

// bytes come out low then high, one per read
task automatic test_order();
    logic [15:0] word;
    test_name = "test_order";
    repeat (5) begin
        word = 16'($urandom);
        run_op(1'b1, word, 1'b0);
    end
    repeat (10) begin
        run_op(1'b0, 16'h0000, 1'b1);
        check_value("rd_ack", 1, 32'(events.rd_ack));
    end
endtask

task automatic test_full();
    test_name = "test_full";
    repeat (15) begin
        run_op(1'b1, 16'($urandom), 1'b0);
    end
    // one word of space left
    check_value("almost_full", 1, 32'(flags.almost_full));
    run_op(1'b1, 16'($urandom), 1'b0);
    check_value("wfull", 1, 32'(flags.wfull));
    check_value("wr_data_cnt", 16, 32'(wr_data_cnt));
    // extra word is dropped
    run_op(1'b1, 16'($urandom), 1'b0);
    check_value("overflow", 1, 32'(events.overflow));
    check_value("wr_ack", 0, 32'(events.wr_ack));
    // slot frees only once both bytes are gone
    run_op(1'b0, 16'h0000, 1'b1);
    check_value("wfull", 1, 32'(flags.wfull));
    run_op(1'b0, 16'h0000, 1'b1);
    check_value("wfull", 0, 32'(flags.wfull));
    while (model_q.size() > 0) begin
        run_op(1'b0, 16'h0000, 1'b1);
    end
endtask

task automatic test_empty();
    test_name = "test_empty";
    run_op(1'b1, 16'($urandom), 1'b0);
    run_op(1'b0, 16'h0000, 1'b1);
    check_value("almost_empty", 1, 32'(flags.almost_empty));
    run_op(1'b0, 16'h0000, 1'b1);
    check_value("rempty", 1, 32'(flags.rempty));
    check_value("almost_empty", 0, 32'(flags.almost_empty));
    // read on an empty fifo
    run_op(1'b0, 16'h0000, 1'b1);
    check_value("underflow", 1, 32'(events.underflow));
    check_value("rd_ack", 0, 32'(events.rd_ack));
endtask

// thresholds: full 12 / 8 words, empty 4 / 10 bytes
task automatic test_prog();
    test_name = "test_prog";
    // climbing from empty, prog_empty holds up to 10 bytes
    for (int i = 1; i <= 16; i++) begin
        run_op(1'b1, 16'($urandom), 1'b0);
        check_value("prog_full", 32'(i >= 12), 32'(flags.prog_full));
        check_value("prog_empty", 32'(2 * i <= 10), 32'(flags.prog_empty));
    end
    // draining, prog_full holds down to 8 words
    for (int n = 31; n >= 0; n--) begin
        run_op(1'b0, 16'h0000, 1'b1);
        check_value("prog_full", 32'((n + 1) / 2 >= 8), 32'(flags.prog_full));
        check_value("prog_empty", 32'(n <= 4), 32'(flags.prog_empty));
    end
endtask

`endif

// ==== test/tb_fifo_top.sv ====
//------------------------------------------------
// testbench for the 16-to-8 width converting fifo
// clock, reset, dut0, byte queue model
// status checker, timeout and closing report
//------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "fifo_defines.svh"

module tb_fifo_top
    import fifo_pkg::*;
();

    // about 240 cycles of tests plus reset, wide margin
    localparam int MAX_CYCLES = 2000;

    // dut ports
    logic         clk;
    logic         rst_n;
    logic         wen;
    logic [15:0]  wdata;
    logic         ren;
    prog_thresh_t thresh;
    logic [7:0]   rdata;
    fifo_flags_t  flags;
    fifo_events_t events;
    wr_cnt_t      wr_data_cnt;
    rd_cnt_t      rd_data_cnt;

    // run bookkeeping
    int    cycle_cnt = 0;
    int    checks_run = 0;
    int    error_count = 0;
    string test_name = "none";

    // bytes in fifo order, oldest at the front
    logic [7:0]   model_q [$];
    logic [7:0]   exp_rdata = 8'h00;
    fifo_events_t exp_events = '0;
    // hysteresis state of the programmable flags
    logic         exp_prog_full = 1'b0;
    logic         exp_prog_empty = 1'b0;

    fifo_top dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .wen         (wen),
        .wdata       (wdata),
        .ren         (ren),
        .thresh      (thresh),
        .rdata       (rdata),
        .flags       (flags),
        .events      (events),
        .wr_data_cnt (wr_data_cnt),
        .rd_data_cnt (rd_data_cnt)
    );

    //------------------------------------------------
    // clock and cycle limit
    //------------------------------------------------
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    initial begin
        wait (cycle_cnt >= MAX_CYCLES);
        $display("timeout: run stopped after %0d cycles without finishing", cycle_cnt);
        $display("CHECKS FAILED");
        $finish;
    end

    //------------------------------------------------
    // model and checks
    //------------------------------------------------
    // one dut edge worth of prog flag hysteresis
    function automatic void update_prog_model();
        int n;
        int words;
        n = model_q.size();
        // a half read word still takes a slot
        words = (n + 1) / 2;
        if (exp_prog_full) begin
            exp_prog_full = (words >= int'(thresh.full_negate));
        end else begin
            exp_prog_full = (words >= int'(thresh.full_assert));
        end
        if (exp_prog_empty) begin
            exp_prog_empty = (n <= int'(thresh.empty_negate));
        end else begin
            exp_prog_empty = (n <= int'(thresh.empty_assert));
        end
        exp_prog_empty = exp_prog_empty && (n < `FIFO_RD_DEPTH);
    endfunction

    task automatic check_value(input string what, input int expected, input int actual);
        checks_run++;
        assert (expected == actual)
        else begin
            $display("CHECK FAILED %s %s: expected %0h, actual %0h",
                     test_name, what, expected, actual);
            error_count++;
        end
    endtask

    // whole status against the queue model
    task automatic check_status();
        fifo_flags_t exp_flags;
        int          n;
        int          words;
        n = model_q.size();
        words = (n + 1) / 2;
        exp_flags.wfull        = (words == `FIFO_WR_DEPTH);
        exp_flags.rempty       = (n == 0);
        exp_flags.almost_full  = (words == `FIFO_WR_DEPTH - 1);
        exp_flags.almost_empty = (n == 1);
        exp_flags.prog_full    = exp_prog_full;
        exp_flags.prog_empty   = exp_prog_empty;
        check_value("flags", 32'(exp_flags), 32'(flags));
        check_value("events", 32'(exp_events), 32'(events));
        check_value("wr_data_cnt", words, 32'(wr_data_cnt));
        check_value("rd_data_cnt", n, 32'(rd_data_cnt));
        check_value("rdata", 32'(exp_rdata), 32'(rdata));
    endtask

    // one strobe cycle, then one idle cycle, checked at the negedge
    task automatic run_op(input logic do_wr, input logic [15:0] word, input logic do_rd);
        int   n;
        logic wr_ok;
        logic rd_ok;
        n = model_q.size();
        // acceptance follows the status before the op edge
        wr_ok = do_wr && ((n + 1) / 2 < `FIFO_WR_DEPTH);
        rd_ok = do_rd && (n > 0);
        @(posedge clk);
        wen   <= do_wr;
        wdata <= word;
        ren   <= do_rd;
        // this edge saw idle inputs
        update_prog_model();
        @(posedge clk);
        wen <= 1'b0;
        ren <= 1'b0;
        if (rd_ok) begin
            exp_rdata = model_q.pop_front();
        end
        // low byte leaves first
        if (wr_ok) begin
            model_q.push_back(word[7:0]);
            model_q.push_back(word[15:8]);
        end
        exp_events = '{wr_ack: wr_ok, rd_ack: rd_ok,
                       overflow: do_wr & ~wr_ok, underflow: do_rd & ~rd_ok};
        update_prog_model();
        @(negedge clk);
        check_status();
    endtask

    `include "tb_fifo_tests.svh"

    //------------------------------------------------
    // main sequence
    //------------------------------------------------
    initial begin
        rst_n  <= 1'b0;
        wen    <= 1'b0;
        ren    <= 1'b0;
        wdata  <= '0;
        thresh <= '{full_assert: 5'd12, full_negate: 5'd8,
                    empty_assert: 6'd4, empty_negate: 6'd10};
        void'($urandom(43));
        repeat (8) @(posedge clk);
        @(negedge clk);
        test_reset();
        @(posedge clk);
        rst_n <= 1'b1;
        test_order();
        test_full();
        test_empty();
        test_prog();
        $display("checks run %0d, errors %0d", checks_run, error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/fifo_ctrl.sv ====
//------------------------------------------------
// fifo control
// write/read pointers and next-pointer logic
// memory enables and addresses
// ack, overflow and underflow pulses
//------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "fifo_defines.svh"

module fifo_ctrl
    import fifo_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   wen,
    input  logic                   ren,
    input  fifo_flags_t            flags,
    output ptr_next_t              nxt,
    output logic                   mem_we,
    output logic [`FIFO_WR_AW-1:0] mem_waddr,
    output logic                   mem_re,
    output logic [`FIFO_RD_AW-1:0] mem_raddr,
    output fifo_events_t           events
);

    // word pointer and byte pointer
    wr_ptr_t wr_ptr;
    rd_ptr_t rd_ptr;

    // accepted operations this cycle
    logic wr_acc;
    logic rd_acc;

    //------------------------------------------------
    // accept logic
    //------------------------------------------------
    // only the full/empty levels gate the strobes
    assign wr_acc = wen & ~flags.wfull;
    assign rd_acc = ren & ~flags.rempty;

    // step by one word or one byte when accepted
    assign nxt.wr = wr_ptr + wr_ptr_t'(wr_acc);
    assign nxt.rd = rd_ptr + rd_ptr_t'(rd_acc);

    //------------------------------------------------
    // pointer registers
    //------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            wr_ptr <= nxt.wr;
            rd_ptr <= nxt.rd;
        end
    end

    //------------------------------------------------
    // memory port
    //------------------------------------------------
    // store at the current word slot
    assign mem_we    = wr_acc;
    assign mem_waddr = wr_ptr[`FIFO_WR_AW-1:0];

    // fetch at the current byte, wrap bit dropped
    // bit 0 later picks the lane inside the word
    assign mem_re    = rd_acc;
    assign mem_raddr = rd_ptr[`FIFO_RD_AW-1:0];

    //------------------------------------------------
    // event pulses
    //------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            events <= '0;
        end else begin
            // ack lines up with stored word / valid rdata
            events.wr_ack    <= wr_acc;
            events.rd_ack    <= rd_acc;
            // rejected strobes, the request itself is dropped
            events.overflow  <= wen & flags.wfull;
            events.underflow <= ren & flags.rempty;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/fifo_defines.svh ====
//------------------------------------------------
// width and depth macros for the 16-to-8 fifo
// data widths, address widths, storage depths
//------------------------------------------------

`ifndef FIFO_DEFINES_SVH
`define FIFO_DEFINES_SVH

//------------------------------------------------
// data widths
//------------------------------------------------
// write side takes whole words
`define FIFO_WR_DW 16
// read side returns single bytes, low byte first
`define FIFO_RD_DW 8

//------------------------------------------------
// address widths and depths
//------------------------------------------------
// word address into the storage
`define FIFO_WR_AW 4
// byte address, one bit wider for the lane select
`define FIFO_RD_AW 5
// capacity seen from either side
`define FIFO_WR_DEPTH 16
`define FIFO_RD_DEPTH 32

`endif

// ==== verilog/fifo_level.sv ====
//------------------------------------------------
// fifo level tracking
// word and byte counts, full/empty
// almost flags, programmable flags with hysteresis
//------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "fifo_defines.svh"

module fifo_level
    import fifo_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  ptr_next_t    nxt,
    input  prog_thresh_t thresh,
    output fifo_flags_t  flags,
    output wr_cnt_t      wr_data_cnt,
    output rd_cnt_t      rd_data_cnt
);

    // empty is the only flag that comes out of reset high
    localparam fifo_flags_t flags_at_reset = '{
        wfull:        1'b0,
        rempty:       1'b1,
        almost_full:  1'b0,
        almost_empty: 1'b0,
        prog_full:    1'b0,
        prog_empty:   1'b0
    };

    // counts from the next-cycle pointers
    wr_cnt_t     wr_cnt_val;
    rd_cnt_t     rd_cnt_val;
    fifo_flags_t flags_d;

    //------------------------------------------------
    // count arithmetic
    //------------------------------------------------
    // half the byte pointer rounds down, so a word slot
    // stays occupied until both of its bytes are gone
    assign wr_cnt_val = nxt.wr - nxt.rd[`FIFO_RD_AW:1];

    // every word holds two bytes
    assign rd_cnt_val = {nxt.wr, 1'b0} - nxt.rd;

    //------------------------------------------------
    // flag decode
    //------------------------------------------------
    always_comb begin
        flags_d.wfull        = (wr_cnt_val == wr_cnt_t'(`FIFO_WR_DEPTH));
        flags_d.rempty       = (rd_cnt_val == '0);
        // one word of space left
        flags_d.almost_full  = (wr_cnt_val == wr_cnt_t'(`FIFO_WR_DEPTH - 1));
        // one byte left to read
        flags_d.almost_empty = (rd_cnt_val == rd_cnt_t'(1));

        // prog_full holds until the level falls below negate
        // a full count already meets any legal threshold
        if (flags.prog_full) begin
            flags_d.prog_full = (wr_cnt_val >= thresh.full_negate);
        end else begin
            flags_d.prog_full = (wr_cnt_val >= thresh.full_assert);
        end

        // prog_empty holds until the level climbs past negate
        if (flags.prog_empty) begin
            flags_d.prog_empty = (rd_cnt_val <= thresh.empty_negate);
        end else begin
            flags_d.prog_empty = (rd_cnt_val <= thresh.empty_assert);
        end
        // never report prog_empty on a completely full fifo
        flags_d.prog_empty = flags_d.prog_empty &
                             (rd_cnt_val < rd_cnt_t'(`FIFO_RD_DEPTH));
    end

    //------------------------------------------------
    // output registers
    //------------------------------------------------
    // values after an edge already include that edge's ops
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flags       <= flags_at_reset;
            wr_data_cnt <= '0;
            rd_data_cnt <= '0;
        end else begin
            flags       <= flags_d;
            wr_data_cnt <= wr_cnt_val;
            rd_data_cnt <= rd_cnt_val;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/fifo_pkg.sv ====
//------------------------------------------------
// shared types for the width converting fifo
// pointers, counts, thresholds, flags, events
// and the two-view memory word
//------------------------------------------------
`default_nettype none

`include "fifo_defines.svh"

package fifo_pkg;

    //------------------------------------------------
    // pointers and counts
    //------------------------------------------------
    // address plus one wrap bit
    typedef logic [`FIFO_WR_AW:0] wr_ptr_t;
    typedef logic [`FIFO_RD_AW:0] rd_ptr_t;
    // one extra bit so a full fifo reads 16 / 32
    typedef logic [`FIFO_WR_AW:0] wr_cnt_t;
    typedef logic [`FIFO_RD_AW:0] rd_cnt_t;

    // written as one word, read back as two byte lanes
    // lane 0 holds the low byte
    typedef union packed {
        logic [`FIFO_WR_DW-1:0]      word;
        logic [1:0][`FIFO_RD_DW-1:0] lane;
    } fifo_word_u;

    // dynamic thresholds with hysteresis
    typedef struct packed {
        wr_cnt_t full_assert;
        wr_cnt_t full_negate;
        rd_cnt_t empty_assert;
        rd_cnt_t empty_negate;
    } prog_thresh_t;

    // status levels, all registered
    typedef struct packed {
        logic wfull;
        logic rempty;
        logic almost_full;
        logic almost_empty;
        logic prog_full;
        logic prog_empty;
    } fifo_flags_t;

    // single cycle pulses
    typedef struct packed {
        logic wr_ack;
        logic rd_ack;
        logic overflow;
        logic underflow;
    } fifo_events_t;

    // pointers as they will be after the current edge
    typedef struct packed {
        wr_ptr_t wr;
        rd_ptr_t rd;
    } ptr_next_t;

endpackage

`default_nettype wire

// ==== verilog/fifo_ram.sv ====
//------------------------------------------------
// fifo storage
// 16-bit write port, 8-bit read port
// registered read data
//------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "fifo_defines.svh"

module fifo_ram
    import fifo_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   we,
    input  logic [`FIFO_WR_AW-1:0] waddr,
    input  fifo_word_u             wdata,
    input  logic                   re,
    input  logic [`FIFO_RD_AW-1:0] raddr,
    output logic [`FIFO_RD_DW-1:0] rdata
);

    // one entry per word slot
    fifo_word_u mem [`FIFO_WR_DEPTH];

    //------------------------------------------------
    // write port
    //------------------------------------------------
    // whole word stored at once
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    //------------------------------------------------
    // read port
    //------------------------------------------------
    // upper address bits pick the word, bit 0 the lane
    // rdata keeps its value when no read is accepted
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata <= '0;
        end else if (re) begin
            rdata <= mem[raddr[`FIFO_RD_AW-1:1]].lane[raddr[0]];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/fifo_top.sv ====
//------------------------------------------------
// top level of the width converting sync fifo
// control, level tracking and storage
//------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "fifo_defines.svh"

module fifo_top
    import fifo_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   wen,
    input  logic [`FIFO_WR_DW-1:0] wdata,
    input  logic                   ren,
    input  prog_thresh_t           thresh,
    output logic [`FIFO_RD_DW-1:0] rdata,
    output fifo_flags_t            flags,
    output fifo_events_t           events,
    output wr_cnt_t                wr_data_cnt,
    output rd_cnt_t                rd_data_cnt
);

    // next-cycle pointers into the level logic
    ptr_next_t nxt;

    // memory port
    logic                   mem_we;
    logic [`FIFO_WR_AW-1:0] mem_waddr;
    logic                   mem_re;
    logic [`FIFO_RD_AW-1:0] mem_raddr;

    // incoming word filled through the whole-word view
    fifo_word_u wr_word;

    assign wr_word.word = wdata;

    //------------------------------------------------
    // pointers, enables, pulses
    //------------------------------------------------
    fifo_ctrl u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .wen       (wen),
        .ren       (ren),
        .flags     (flags),
        .nxt       (nxt),
        .mem_we    (mem_we),
        .mem_waddr (mem_waddr),
        .mem_re    (mem_re),
        .mem_raddr (mem_raddr),
        .events    (events)
    );

    // counts and all six flags
    fifo_level u_level (
        .clk         (clk),
        .rst_n       (rst_n),
        .nxt         (nxt),
        .thresh      (thresh),
        .flags       (flags),
        .wr_data_cnt (wr_data_cnt),
        .rd_data_cnt (rd_data_cnt)
    );

    // word in, byte out
    fifo_ram u_ram (
        .clk   (clk),
        .rst_n (rst_n),
        .we    (mem_we),
        .waddr (mem_waddr),
        .wdata (wr_word),
        .re    (mem_re),
        .raddr (mem_raddr),
        .rdata (rdata)
    );

endmodule

`default_nettype wire
